// ==== hw/access_fsm.sv ====
// access sequencer for the memory subsystem
// runs the power-up clear, then serves the four-phase host port

`timescale 1ns/1ns

module access_fsm
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,        // host request, four-phase
    input  mem_req_t host_req,   // held stable while req is high
    output logic     ack,        // access done
    output logic     busy,       // clear in progress
    output data_t    rdata,      // read result, valid with ack
    output logic     clr_step,   // advance the clear counter
    input  addr_t    clr_addr,   // word being cleared
    input  logic     clr_last,   // final clear word
    output logic     mem_ce,
    output logic     mem_we,
    output mask_t    mem_wmask,
    output addr_t    mem_addr,
    output data_t    mem_din,
    input  data_t    mem_dout    // tile read data, one cycle late
);

    mem_state_t state;
    mem_state_t state_nxt;
    mem_req_t   req_q;  // latched host request

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            CLEAR:   if (clr_last) state_nxt = IDLE;  // top word written this cycle
            IDLE:    if (req) state_nxt = ISSUE;
            ISSUE:   state_nxt = req_q.write ? HOLD : CAPTURE;
            CAPTURE: state_nxt = HOLD;
            HOLD:    if (!req) state_nxt = IDLE;      // host released
            default: state_nxt = CLEAR;
        endcase
    end

    // control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CLEAR;
            ack   <= 1'b0;
        end else begin
            state <= state_nxt;
            ack   <= (state == HOLD) && req;  // drops on the edge after req falls
        end
    end

    // request and read data registers
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            req_q <= host_req;
        end
        if (state == CAPTURE) begin
            rdata <= mem_dout;  // stays put through the ack phase
        end
    end

    assign busy     = (state == CLEAR);
    assign clr_step = (state == CLEAR);

    // memory port, zero fill during clear
    assign mem_ce    = (state == CLEAR) || (state == ISSUE);
    assign mem_we    = (state == CLEAR) || (state == ISSUE && req_q.write);
    assign mem_wmask = (state == CLEAR) ? '1 : req_q.wmask;  // full mask for the fill
    assign mem_addr  = (state == CLEAR) ? clr_addr : req_q.addr;
    assign mem_din   = (state == CLEAR) ? '0 : req_q.wdata;

endmodule

// ==== hw/clear_counter.sv ====
// word address counter for the power-up zero fill
// counts up on step and stops at the top word

`timescale 1ns/1ns

module clear_counter
    import mem_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  step,  // advance to the next word
    output addr_t addr,  // word being cleared
    output logic  last   // addr is the top word
);

    assign last = (addr == '1);  // all ones is the final word

    // no wrap, parks on the top word once reached
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (step && !last) begin
            addr <= addr + addr_t'(1);
        end
    end

endmodule

// ==== hw/mem_pkg.sv ====
// memory subsystem shared definitions
// fixed word and address widths, host request layout and fsm states

package mem_pkg;

    localparam int DATA_W  = 32;  // host word width
    localparam int ADDR_W  = 10;  // word address width
    localparam int MACRO_W = 8;   // data width of one hard macro

    typedef logic [DATA_W-1:0] data_t;  // memory word
    typedef logic [DATA_W-1:0] mask_t;  // per bit write mask, 1 = write
    typedef logic [ADDR_W-1:0] addr_t;  // word address

    // one host access as seen on the four-phase port
    typedef struct packed {
        logic  write;  // 1 = write, 0 = read
        addr_t addr;   // word address
        data_t wdata;  // write data
        mask_t wmask;  // bits to update on a write
    } mem_req_t;

    // access sequencer states
    typedef enum logic [2:0] {
        CLEAR,    // power-up zero fill
        IDLE,     // waiting for req
        ISSUE,    // memory access on the port
        CAPTURE,  // read data arriving from the tiles
        HOLD      // ack phase, wait for req to drop
    } mem_state_t;

endpackage

// ==== hw/mem_subsys_top.sv ====
// single port memory subsystem with power-up clear
// host port is four-phase req/ack, storage is a grid of 8-bit macros

`timescale 1ns/1ns

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter int MACRO_AW = 8  // macro depth, log2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,       // host request
    input  mem_req_t host_req,  // access to perform
    output logic     ack,       // access done
    output data_t    rdata,     // read data
    output logic     busy       // power-up clear running
);

    logic  clr_step;
    addr_t clr_addr;
    logic  clr_last;
    logic  mem_ce;
    logic  mem_we;
    mask_t mem_wmask;
    addr_t mem_addr;
    data_t mem_din;
    data_t mem_dout;

    access_fsm u_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .host_req (host_req),
        .ack      (ack),
        .busy     (busy),
        .rdata    (rdata),
        .clr_step (clr_step),
        .clr_addr (clr_addr),
        .clr_last (clr_last),
        .mem_ce   (mem_ce),
        .mem_we   (mem_we),
        .mem_wmask(mem_wmask),
        .mem_addr (mem_addr),
        .mem_din  (mem_din),
        .mem_dout (mem_dout)
    );

    clear_counter u_clr (
        .clk  (clk),
        .rst_n(rst_n),
        .step (clr_step),
        .addr (clr_addr),
        .last (clr_last)
    );

    spram_tiler #(
        .MACRO_AW(MACRO_AW)
    ) u_mem (
        .clk  (clk),
        .ce   (mem_ce),
        .we   (mem_we),
        .wmask(mem_wmask),
        .addr (mem_addr),
        .din  (mem_din),
        .dout (mem_dout)
    );

endmodule

// ==== hw/spram_tiler.sv ====
// single port memory built from a grid of 8-bit macros
// upper address bits pick the bank, each byte lane is one macro

`timescale 1ns/1ns

module spram_tiler
    import mem_pkg::*;
#(
    parameter int MACRO_AW = 8  // depth of one macro, log2
) (
    input  logic  clk,
    input  logic  ce,     // access enable
    input  logic  we,     // write enable
    input  mask_t wmask,  // per bit write mask
    input  addr_t addr,   // word address
    input  data_t din,    // write data
    output data_t dout    // read data, one cycle after the read
);

    localparam int BANKS  = 2 ** (ADDR_W - MACRO_AW);                // rows of macros
    localparam int LANES  = DATA_W / MACRO_W;                        // byte lanes per bank
    localparam int BANK_W = (ADDR_W > MACRO_AW) ? ADDR_W - MACRO_AW : 1;

    logic [BANK_W-1:0]   bank_sel;  // bank of the current access
    logic [BANK_W-1:0]   sel_q;     // bank of the last read
    logic [MACRO_AW-1:0] macro_a;   // in-bank address

    wire data_t bank_dout [BANKS];  // raw q of each bank

    assign macro_a = addr[MACRO_AW-1:0];

    if (BANKS == 1) begin : g_one_bank
        assign bank_sel = '0;  // everything fits one row
    end else begin : g_multi_bank
        assign bank_sel = addr[ADDR_W-1:MACRO_AW];
    end

    // follows the macro read latency so dout picks the right row
    always_ff @(posedge clk) begin
        if (ce && !we) begin
            sel_q <= bank_sel;  // only reads move q
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic hit;  // this row is addressed

        assign hit = (bank_sel == BANK_W'(b));

        for (genvar l = 0; l < LANES; l++) begin : g_lane
            sram_macro_model #(
                .MACRO_AW(MACRO_AW)
            ) u_macro (
                .clk (clk),
                .cen (~(ce && hit)),                        // low active pins
                .gwen(~(we && hit)),
                .wen (~wmask[l*MACRO_W +: MACRO_W]),
                .a   (macro_a),
                .d   (din[l*MACRO_W +: MACRO_W]),
                .q   (bank_dout[b][l*MACRO_W +: MACRO_W])
            );
        end
    end

    // zero the stale rows, then or them together
    always_comb begin
        dout = '0;
        for (int b = 0; b < BANKS; b++) begin
            dout |= (sel_q == BANK_W'(b)) ? bank_dout[b] : '0;
        end
    end

endmodule

// ==== hw/sram_macro_model.sv ====
// behavioral stand-in for an 8-bit-wide single port hard macro
// low active controls, per bit write enables, one cycle read latency

`timescale 1ns/1ns

module sram_macro_model
    import mem_pkg::*;
#(
    parameter int MACRO_AW = 8  // macro address width
) (
    input  logic                clk,
    input  logic                cen,   // chip enable, low active
    input  logic                gwen,  // global write enable, low active
    input  logic [MACRO_W-1:0]  wen,   // bit write enables, low active
    input  logic [MACRO_AW-1:0] a,     // macro address
    input  logic [MACRO_W-1:0]  d,     // write data
    output logic [MACRO_W-1:0]  q      // registered read data
);

    localparam int DEPTH = 2 ** MACRO_AW;

    logic [MACRO_W-1:0] mem [DEPTH];  // storage array

    // write keeps bits whose wen is high, read loads q
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!gwen) begin
                mem[a] <= (mem[a] & wen) | (d & ~wen);  // masked update
            end else begin
                q <= mem[a];  // read, q holds otherwise
            end
        end
    end

endmodule

// ==== tests/mem_subsys_properties.sv ====
// handshake checks for the memory subsystem host port
// bound into the top level, watches req, ack, busy and rdata

`timescale 1ns/1ns

module mem_subsys_properties
    import mem_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  req,
    input logic  ack,
    input logic  busy,
    input data_t rdata
);

    // two samples of low req and ack must be gone
    ack_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        (!req && $past(!req)) |-> !ack)
        else $error("ack still high after req was low for two cycles");

    // no access completes during the zero fill
    ack_not_in_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> !busy)
        else $error("ack rose while the power-up clear was running");

    // ack follows req down one cycle later in phase 4
    ack_drop_timing: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |=> !ack)
        else $error("ack did not fall one cycle after req fell");

    // read data held through the whole ack phase
    rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> $stable(rdata))
        else $error("rdata changed while ack was high");

endmodule

bind mem_subsys_top mem_subsys_properties u_props (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (req),
    .ack  (ack),
    .busy (busy),
    .rdata(rdata)
);

// ==== tests/tb_mem_subsys.sv ====
// testbench for the memory subsystem
// four-phase host driver, reference array, per-test report and watchdog

`timescale 1ns/1ns

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam int TB_MACRO_AW = 8;                           // gives four banks
    localparam int WORDS       = 2 ** ADDR_W;
    localparam int BANKS       = 2 ** (ADDR_W - TB_MACRO_AW);
    localparam int N_ACCESS    = 145;                         // all accesses of all tests
    localparam int WATCHDOG_NS = (WORDS + 20 * N_ACCESS) * 10 * 2;

    logic     clk;
    logic     rst_n;
    logic     req;
    mem_req_t host_req;
    logic     ack;
    data_t    rdata;
    logic     busy;

    data_t  ref_mem [WORDS];        // expected memory contents
    integer seed = 32'hdcc1_acef;
    int     pass_cnt;
    int     fail_cnt;
    int     fails_at_start;         // fail_cnt when the test began
    string  test_name;

    mem_subsys_top #(
        .MACRO_AW(TB_MACRO_AW)
    ) mem_subsys_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .host_req(host_req),
        .ack     (ack),
        .rdata   (rdata),
        .busy    (busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;  // 10 ns period

    function automatic addr_t pick_addr();
        return addr_t'($random(seed));
    endfunction

    function automatic data_t random_word();
        return data_t'($random(seed));
    endfunction

    task automatic start_test(input string name);
        test_name      = name;
        fails_at_start = fail_cnt;
    endtask

    task automatic end_test();
        $display("test %s finished, %0d errors", test_name, fail_cnt - fails_at_start);
    endtask

    // one four-phase access, entered 1 ns after an edge with ack low
    task automatic run_access(input logic write, input addr_t addr, input data_t wdata,
                              input mask_t wmask, input int extra_hold);
        data_t expected;
        host_req = '{write: write, addr: addr, wdata: wdata, wmask: wmask};
        req      = 1'b1;
        do begin
            @(posedge clk);
            #1;                          // outputs settled after the edge
        end while (ack !== 1'b1);
        assert (busy === 1'b0) else begin
            $display("test %s: access finished while the clear was still running", test_name);
            fail_cnt++;
        end
        if (write) begin
            ref_mem[addr] = (ref_mem[addr] & ~wmask) | (wdata & wmask);  // per bit merge
        end else begin
            expected = ref_mem[addr];
            assert (rdata === expected) pass_cnt++;
            else begin
                $display("mismatch test %s addr %h expected %h actual %h",
                         test_name, addr, expected, rdata);
                fail_cnt++;
            end
        end
        repeat (extra_hold) begin
            @(posedge clk);              // host slow to release
            #1;
        end
        req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (ack !== 1'b0);
    endtask

    initial begin
        addr_t a_list [20];
        addr_t low_addr;
        addr_t a;
        data_t base;
        req      = 1'b0;
        host_req = '0;
        rst_n    = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        foreach (ref_mem[i]) ref_mem[i] = '0;  // matches the zero fill
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        start_test("req_during_clear");
        assert (busy === 1'b1) else begin
            $display("test %s: busy low right after reset", test_name);
            fail_cnt++;
        end
        run_access(1'b0, pick_addr(), '0, '0, 0);  // waits out the clear
        end_test();

        start_test("power_up_clear");
        for (int i = 0; i < 16; i++) run_access(1'b0, pick_addr(), '0, '0, 0);
        end_test();

        start_test("full_mask");
        for (int i = 0; i < 20; i++) begin
            a_list[i] = pick_addr();
            run_access(1'b1, a_list[i], random_word(), '1, 0);
        end
        for (int i = 0; i < 20; i++) run_access(1'b0, a_list[i], '0, '0, 0);
        end_test();

        start_test("partial_mask");
        for (int i = 0; i < 20; i++) begin
            a = pick_addr();
            run_access(1'b1, a, random_word(), '1, 0);             // known background
            run_access(1'b1, a, random_word(), random_word(), 0);  // random mask
            run_access(1'b0, a, '0, '0, 0);
        end
        end_test();

        start_test("bank_separation");
        low_addr = pick_addr();
        base     = random_word();
        for (int b = 0; b < BANKS; b++) begin
            a = {(ADDR_W - TB_MACRO_AW)'(b), low_addr[TB_MACRO_AW-1:0]};
            run_access(1'b1, a, base + b * 32'h0101_0101, '1, 0);  // every byte differs
        end
        for (int b = 0; b < BANKS; b++) begin
            a = {(ADDR_W - TB_MACRO_AW)'(b), low_addr[TB_MACRO_AW-1:0]};
            run_access(1'b0, a, '0, '0, 0);
        end
        end_test();

        start_test("back_pressure");
        for (int i = 0; i < 20; i++) begin
            run_access(logic'($random(seed) & 1), pick_addr(), random_word(), random_word(),
                       $unsigned($random(seed)) % 6);              // 0 to 5 extra cycles
        end
        end_test();

        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // clear time plus a generous bound per access
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the DUT stopped answering the host");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/mem_pkg.sv
hw/sram_macro_model.sv
hw/spram_tiler.sv
hw/clear_counter.sv
hw/access_fsm.sv
hw/mem_subsys_top.sv
tests/mem_subsys_properties.sv
tests/tb_mem_subsys.sv
